/* verilog/vdc_settings.svh */
// ==============================
// build settings for the vram interface
// ram size, slot length, fifo depth
// and column counter width
// ==============================
`ifndef VDC_SETTINGS_SVH
`define VDC_SETTINGS_SVH

// video ram address width, 4096 bytes
`define VDC_RAM_ADDR_BITS 12

// clocks per character column slot
`define VDC_SLOT_CYCLES 4

// display fifo entries, also the initial credit count
`define VDC_FIFO_DEPTH 8

// width of the column and line counters
`define VDC_COL_BITS 8

`endif

/* verilog/vdc_pkg.sv */
// ==============================
// shared types of the vram interface
// action enums, cpu request/response,
// display registers, fetched word
// ==============================
`include "vdc_settings.svh"

package vdc_pkg;

	typedef enum logic [2:0] {
		CA_IDLE,
		CA_READ,
		CA_WRITE,
		CA_FILL,
		CA_COPY_RD,
		CA_COPY_WR
	} cpu_action_t;

	typedef enum logic [2:0] {
		RA_IDLE,
		RA_SCRN,
		RA_RFSH,
		RA_CPU,
		RA_ERASE
	} ram_action_t;

	typedef struct packed {
		logic                          valid;
		logic                          write;
		logic [`VDC_RAM_ADDR_BITS-1:0] addr;
		logic [7:0]                    data;
	} cpu_req_t;

	typedef struct packed {
		logic       done;   // last clock of the serving slot
		logic [7:0] rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic [`VDC_COL_BITS-1:0] ht;   // horizontal total minus one
		logic [`VDC_COL_BITS-1:0] hd;   // displayed columns
		logic [`VDC_COL_BITS-1:0] ai;   // extra address step per line
		logic [`VDC_COL_BITS-1:0] vt;   // line total minus one
		logic [15:0]              ds;   // display start
		logic [`VDC_COL_BITS-1:0] drr;  // refresh slots per line
	} disp_cfg_t;

	typedef struct packed {
		logic [7:0]               data;
		logic [`VDC_COL_BITS-1:0] col;
		logic                     first_of_line;
	} disp_word_t;

endpackage

/* verilog/vdc_cpu_port.sv */
// ==============================
// cpu register port
// register decode, ua/ba/wc/da storage
// and the cpu action fsm
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_cpu_port (
	input  logic              clk,
	input  logic              reset,
	input  logic [5:0]        reg_sel,
	input  logic              reg_wr,
	input  logic              reg_rd,
	input  logic [7:0]        reg_wdata,
	input  logic              copy_mode,
	input  vdc_pkg::cpu_rsp_t cpu_rsp,
	input  logic              erasing,
	output logic [7:0]        reg_rdata,
	output vdc_pkg::cpu_req_t cpu_req,
	output logic              busy
);
	localparam int AW = `VDC_RAM_ADDR_BITS;

	vdc_pkg::cpu_action_t action;
	logic [15:0] ua;  // update address
	logic [15:0] ba;  // block copy source
	logic [7:0]  wc;
	logic [7:0]  cnt;  // bytes left in fill or copy
	logic [7:0]  da;   // latched read data
	logic [7:0]  wda;  // last written data
	logic [7:0]  cda;  // copy byte in flight
	logic        settle;

	assign busy = settle || erasing || action != vdc_pkg::CA_IDLE;

	always_comb begin
		cpu_req.valid = action != vdc_pkg::CA_IDLE;
		cpu_req.write = action inside {vdc_pkg::CA_WRITE, vdc_pkg::CA_FILL, vdc_pkg::CA_COPY_WR};
		cpu_req.addr  = action == vdc_pkg::CA_COPY_RD ? ba[AW-1:0] : ua[AW-1:0];
		cpu_req.data  = action == vdc_pkg::CA_COPY_WR ? cda : wda;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			action <= vdc_pkg::CA_IDLE;
			settle <= 1'b1;
			ua     <= '0;
			ba     <= '0;
			wc     <= '0;
			cnt    <= '0;
			da     <= '0;
			wda    <= '0;
		end else begin
			settle <= 1'b0;
			if (cpu_rsp.done) begin
				case (action)
					vdc_pkg::CA_READ: begin
						da     <= cpu_rsp.rdata;
						action <= vdc_pkg::CA_IDLE;
					end
					vdc_pkg::CA_WRITE: begin
						ua     <= ua + 16'd1;
						action <= vdc_pkg::CA_READ;  // reload da from the new address
					end
					vdc_pkg::CA_FILL: begin
						ua     <= ua + 16'd1;
						cnt    <= cnt - 8'd1;
						action <= cnt == 8'd1 ? vdc_pkg::CA_IDLE : vdc_pkg::CA_FILL;
					end
					vdc_pkg::CA_COPY_RD: begin
						cda    <= cpu_rsp.rdata;
						ba     <= ba + 16'd1;
						action <= vdc_pkg::CA_COPY_WR;
					end
					vdc_pkg::CA_COPY_WR: begin
						ua     <= ua + 16'd1;
						cnt    <= cnt - 8'd1;
						action <= cnt == 8'd1 ? vdc_pkg::CA_IDLE : vdc_pkg::CA_COPY_RD;
					end
					default: action <= vdc_pkg::CA_IDLE;
				endcase
			end
			if (reg_wr) begin
				case (reg_sel)
					6'd18: begin
						ua[15:8] <= reg_wdata;
						action   <= vdc_pkg::CA_READ;
					end
					6'd19: begin
						ua[7:0] <= reg_wdata;
						action  <= vdc_pkg::CA_READ;
					end
					6'd30: begin
						wc     <= reg_wdata;
						cnt    <= reg_wdata;  // zero runs 256 bytes
						action <= copy_mode ? vdc_pkg::CA_COPY_RD : vdc_pkg::CA_FILL;
					end
					6'd31: begin
						wda    <= reg_wdata;
						action <= vdc_pkg::CA_WRITE;
					end
					6'd32: ba[15:8] <= reg_wdata;
					6'd33: ba[7:0]  <= reg_wdata;
					default: ;
				endcase
			end else if (reg_rd && reg_sel == 6'd31) begin
				ua     <= ua + 16'd1;  // return old da, prefetch the next byte
				action <= vdc_pkg::CA_READ;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_rd) begin
			case (reg_sel)
				6'd18:   reg_rdata <= ua[15:8];
				6'd19:   reg_rdata <= ua[7:0];
				6'd30:   reg_rdata <= wc;
				6'd31:   reg_rdata <= da;
				6'd32:   reg_rdata <= ba[15:8];
				6'd33:   reg_rdata <= ba[7:0];
				default: reg_rdata <= 8'h00;
			endcase
		end
	end

endmodule

/* verilog/vdc_slot_sched.sv */
// ==============================
// ram slot scheduler
// column/line counters, slot owner pick,
// display and refresh fetch, reset erase
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_slot_sched (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          init_ram,
	input  vdc_pkg::disp_cfg_t            cfg,
	input  vdc_pkg::cpu_req_t             cpu_req,
	input  logic                          fifo_room,
	input  logic [7:0]                    ram_rdata,
	output vdc_pkg::cpu_rsp_t             cpu_rsp,
	output logic                          ram_we,
	output logic [`VDC_RAM_ADDR_BITS-1:0] ram_addr,
	output logic [7:0]                    ram_wdata,
	output logic                          disp_push,
	output vdc_pkg::disp_word_t           disp_word,
	output logic                          erasing
);
	localparam int AW = `VDC_RAM_ADDR_BITS;
	localparam int CB = `VDC_COL_BITS;
	localparam int SB = $clog2(`VDC_SLOT_CYCLES);
	localparam logic [SB-1:0] SLOT_LAST = SB'(`VDC_SLOT_CYCLES - 1);

	vdc_pkg::ram_action_t owner;
	logic [SB-1:0] sc;  // clock within the slot
	logic [CB-1:0] col;
	logic [CB-1:0] line;
	logic [AW-1:0] line_start;
	logic [AW-1:0] rfsh_addr;
	logic [AW-1:0] erase_addr;
	logic [AW-1:0] slot_addr;
	logic [7:0]    slot_wdata;
	logic          slot_we;
	logic          stall;  // display column skipped for lack of fifo room
	logic          slot_start;
	logic          slot_end;
	logic          in_disp;
	logic          in_rfsh;

	assign slot_start = sc == '0;
	assign slot_end   = sc == SLOT_LAST;
	assign in_disp    = col < cfg.hd;
	assign in_rfsh    = !in_disp && ({1'b0, col} < {1'b0, cfg.hd} + {1'b0, cfg.drr});
	assign erasing    = owner == vdc_pkg::RA_ERASE;

	// the erase owns the ram on every clock, slots own it otherwise
	always_comb begin
		if (erasing) begin
			ram_we    = 1'b1;
			ram_addr  = erase_addr;
			ram_wdata = erase_addr[0] ? 8'h00 : 8'hFF;
		end else begin
			ram_we    = slot_we;
			ram_addr  = slot_addr;
			ram_wdata = slot_wdata;
		end
	end

	always_comb begin
		cpu_rsp.done            = owner == vdc_pkg::RA_CPU && slot_end;
		cpu_rsp.rdata           = ram_rdata;
		disp_push               = owner == vdc_pkg::RA_SCRN && slot_end;
		disp_word.data          = ram_rdata;
		disp_word.col           = col;  // col holds until the slot ends
		disp_word.first_of_line = col == '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			owner      <= init_ram ? vdc_pkg::RA_ERASE : vdc_pkg::RA_IDLE;
			erase_addr <= '0;
			sc         <= '0;
			col        <= '0;
			line       <= '0;
			line_start <= AW'(cfg.ds);
			rfsh_addr  <= '0;
			slot_we    <= 1'b0;
			stall      <= 1'b0;
		end else if (erasing) begin
			erase_addr <= erase_addr + 1'b1;
			if (&erase_addr)
				owner <= vdc_pkg::RA_IDLE;
		end else begin
			slot_we <= 1'b0;  // write pulse lasts one clock
			sc      <= slot_end ? '0 : sc + 1'b1;
			if (slot_start) begin
				stall <= in_disp && !fifo_room;
				if (in_disp && fifo_room) begin
					owner     <= vdc_pkg::RA_SCRN;
					slot_addr <= line_start + AW'(col);
				end else if (in_rfsh) begin
					owner     <= vdc_pkg::RA_RFSH;
					slot_addr <= rfsh_addr;
					rfsh_addr <= rfsh_addr + 1'b1;
				end else if (cpu_req.valid) begin
					owner      <= vdc_pkg::RA_CPU;  // also takes stalled display slots
					slot_addr  <= cpu_req.addr;
					slot_wdata <= cpu_req.data;
					slot_we    <= cpu_req.write;
				end else begin
					owner <= vdc_pkg::RA_IDLE;
				end
			end
			if (slot_end && !stall) begin
				if (col == cfg.ht) begin
					col <= '0;
					if (line == cfg.vt) begin
						line       <= '0;
						line_start <= AW'(cfg.ds);
					end else begin
						line       <= line + 1'b1;
						line_start <= line_start + AW'(cfg.hd) + AW'(cfg.ai);
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/vdc_vram.sv */
// ==============================
// video ram
// single port, registered read
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_vram (
	input  logic                          clk,
	input  logic                          we,
	input  logic [`VDC_RAM_ADDR_BITS-1:0] addr,
	input  logic [7:0]                    wdata,
	output logic [7:0]                    rdata
);
	logic [7:0] mem [2**`VDC_RAM_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];  // old data on a write cycle
	end

endmodule

/* verilog/vdc_fetch_out.sv */
// ==============================
// display output stage
// byte fifo toward the display sink
// with credit based flow control
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_fetch_out (
	input  logic                clk,
	input  logic                reset,
	input  logic                disp_push,
	input  vdc_pkg::disp_word_t disp_word,
	input  logic                credit_ret,
	output logic                fifo_room,
	output logic                out_valid,
	output vdc_pkg::disp_word_t out_word
);
	localparam int DEPTH = `VDC_FIFO_DEPTH;
	localparam int PW = $clog2(DEPTH);
	localparam int CW = PW + 1;
	localparam logic [CW-1:0] DEPTH_W = CW'(DEPTH);

	vdc_pkg::disp_word_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;    // entries held until popped
	logic [CW-1:0] credits;  // words the sink can still take
	logic          pop;

	// a push lands on the last clock of its slot, so at the next slot
	// start nothing is in flight and the held count is the exact reservation
	assign fifo_room = count != DEPTH_W;
	assign pop = count != '0 && credits != '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= DEPTH_W;
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
			if (disp_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count   <= count + CW'(disp_push) - CW'(pop);
			credits <= credits - CW'(pop) + CW'(credit_ret);  // one credit per valid
		end
	end

	always_ff @(posedge clk) begin
		if (disp_push)
			mem[wr_ptr] <= disp_word;
		if (pop)
			out_word <= mem[rd_ptr];
	end

endmodule

/* verilog/vdc_ramiface_top.sv */
// ==============================
// vram interface top level
// cpu port, slot scheduler, ram
// and display output stage
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_ramiface_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                init_ram,
	input  logic                copy_mode,
	input  vdc_pkg::disp_cfg_t  cfg,
	input  logic [5:0]          reg_sel,
	input  logic                reg_wr,
	input  logic                reg_rd,
	input  logic [7:0]          reg_wdata,
	output logic [7:0]          reg_rdata,
	output logic                busy,
	output logic                out_valid,
	output vdc_pkg::disp_word_t out_word,
	input  logic                credit_ret
);
	vdc_pkg::cpu_req_t             cpu_req;
	vdc_pkg::cpu_rsp_t             cpu_rsp;
	vdc_pkg::disp_word_t           disp_word;
	logic                          disp_push;
	logic                          fifo_room;
	logic                          erasing;
	logic                          ram_we;
	logic [`VDC_RAM_ADDR_BITS-1:0] ram_addr;
	logic [7:0]                    ram_wdata;
	logic [7:0]                    ram_rdata;

	vdc_cpu_port u_cpu_port (
		.clk(clk), .reset(reset), .reg_sel(reg_sel), .reg_wr(reg_wr), .reg_rd(reg_rd),
		.reg_wdata(reg_wdata), .copy_mode(copy_mode), .cpu_rsp(cpu_rsp),
		.erasing(erasing), .reg_rdata(reg_rdata), .cpu_req(cpu_req), .busy(busy)
	);

	vdc_slot_sched u_slot_sched (
		.clk(clk), .reset(reset), .init_ram(init_ram), .cfg(cfg), .cpu_req(cpu_req),
		.fifo_room(fifo_room), .ram_rdata(ram_rdata), .cpu_rsp(cpu_rsp),
		.ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.disp_push(disp_push), .disp_word(disp_word), .erasing(erasing)
	);

	vdc_vram u_vram (
		.clk(clk), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
	);

	vdc_fetch_out u_fetch_out (
		.clk(clk), .reset(reset), .disp_push(disp_push), .disp_word(disp_word),
		.credit_ret(credit_ret), .fifo_room(fifo_room), .out_valid(out_valid),
		.out_word(out_word)
	);

endmodule

/* sim/vdc_assertions.sv */
// ==============================
// bound checks on the slot scheduler
// and the display fifo
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_assertions (
	input logic                               clk,
	input logic                               reset,
	input logic                               ram_we,
	input logic                               we_allowed,
	input logic                               fifo_push,
	input logic [$clog2(`VDC_FIFO_DEPTH):0] fifo_count,
	input logic [$clog2(`VDC_FIFO_DEPTH):0] credits
);
	localparam int DEPTH = `VDC_FIFO_DEPTH;

	we_in_owned_slot: assert property (@(posedge clk) disable iff (reset) ram_we |-> we_allowed)
		else $error("ram write outside an erase or a matching cpu write slot");

	no_fifo_overflow: assert property (@(posedge clk) disable iff (reset)
		fifo_push |-> fifo_count < DEPTH)
		else $error("display fifo overflow");

	credits_bounded: assert property (@(posedge clk) disable iff (reset) credits <= DEPTH)
		else $error("credit count above fifo depth");

endmodule

bind vdc_slot_sched vdc_assertions u_sched_chk (
	.clk(clk), .reset(reset), .ram_we(ram_we),
	.we_allowed(owner == vdc_pkg::RA_ERASE || (owner == vdc_pkg::RA_CPU && cpu_req.valid
		&& cpu_req.write && cpu_req.addr == ram_addr && cpu_req.data == ram_wdata)),
	.fifo_push(1'b0), .fifo_count('0), .credits('0)
);

bind vdc_fetch_out vdc_assertions u_fifo_chk (
	.clk(clk), .reset(reset), .ram_we(1'b0), .we_allowed(1'b1),
	.fifo_push(disp_push), .fifo_count(count), .credits(credits)
);

/* sim/vdc_tb.sv */
// ==============================
// testbench for the vram interface
// stimulus, memory model, stream compare,
// watchdog and report
// ==============================
`timescale 1ns/10ps
`include "vdc_settings.svh"

module vdc_tb;
	localparam int HT = 15;
	localparam int HD = 8;
	localparam int AI = 4;
	localparam int VT = 3;
	localparam int DS = 16'h100;
	localparam int DRR = 2;
	localparam int RAM_SIZE = 2**`VDC_RAM_ADDR_BITS;
	localparam int IDLE_LIMIT = 6000;
	// erase, then up to 450 cpu accesses that each may wait a full line
	localparam int WATCH_CLKS = RAM_SIZE + 450 * (HT + 1) * `VDC_SLOT_CYCLES + 2000;

	logic clk = 1'b0;
	logic reset;
	logic init_ram;
	logic copy_mode;
	vdc_pkg::disp_cfg_t cfg;
	logic [5:0] reg_sel;
	logic reg_wr;
	logic reg_rd;
	logic [7:0] reg_wdata;
	logic [7:0] reg_rdata;
	logic busy;
	logic out_valid;
	vdc_pkg::disp_word_t out_word;
	logic credit_ret;

	logic [7:0] ref_mem [RAM_SIZE];
	logic [15:0] lfsr = 16'd43;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int err_mark = 0;
	int valids_seen = 0;
	int credits_given = 0;
	int held_words = 0;
	int exp_start = DS;
	int exp_col = 0;
	int exp_line = 0;
	int cyc = 0;
	logic hold = 1'b0;
	logic data_chk = 1'b1;

	vdc_ramiface_top u_dut (
		.clk(clk), .reset(reset), .init_ram(init_ram), .copy_mode(copy_mode), .cfg(cfg),
		.reg_sel(reg_sel), .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata), .busy(busy), .out_valid(out_valid), .out_word(out_word),
		.credit_ret(credit_ret)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16,14,13,11
	endfunction

	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic logic [7:0] ref_byte(input int a);
		return ref_mem[a % RAM_SIZE];
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < IDLE_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (busy) begin
			errors++;
			$display("busy did not fall within %0d cycles at %0t ns", IDLE_LIMIT, $time);
		end
	endtask

	task automatic wait_words(input int target);
		int n;
		n = 0;
		while (valids_seen < target && n < IDLE_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (valids_seen < target) begin
			errors++;
			$display("display stream stopped at %0d words, %0t ns", valids_seen, $time);
		end
	endtask

	task automatic reg_write(input logic [5:0] sel, input logic [7:0] d);
		reg_sel   = sel;
		reg_wdata = d;
		reg_wr    = 1'b1;
		@(posedge clk);
		#1;
		reg_wr = 1'b0;
		wait_idle();
	endtask

	task automatic read_da(output logic [7:0] d);
		reg_sel = 6'd31;
		reg_rd  = 1'b1;
		@(posedge clk);
		#1;
		reg_rd = 1'b0;
		d = reg_rdata;
		wait_idle();
	endtask

	task automatic set_ua(input int a);
		reg_write(6'd18, 8'(a >> 8));
		reg_write(6'd19, 8'(a));
	endtask

	task automatic write_da(input int a, input logic [7:0] v);
		reg_write(6'd31, v);  // ua must already point at a
		ref_mem[a % RAM_SIZE] = v;
	endtask

	task automatic read_back(input string what, input int first, input int last);
		logic [7:0] d;
		set_ua(first);
		for (int a = first; a <= last; a++) begin
			read_da(d);
			check(what, d, ref_byte(a));
		end
	endtask

	// sink side, credits go back one per clock unless withheld
	always @(posedge clk) begin : sink
		logic give;
		give = !hold && credits_given < valids_seen;
		#1;
		credit_ret = give;
		if (give)
			credits_given++;
	end

	// display stream compare against the line address rule
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			if (data_chk)
				check("display data", out_word.data, ref_byte(exp_start + exp_col));
			check("display col", out_word.col, exp_col);
			check("first_of_line", out_word.first_of_line, exp_col == 0);
			valids_seen++;
			if (hold)
				held_words++;
			if (exp_col == HD - 1) begin
				exp_col = 0;
				if (exp_line == VT) begin
					exp_line  = 0;
					exp_start = DS;
				end else begin
					exp_line++;
					exp_start = exp_start + HD + AI;
				end
			end else begin
				exp_col++;
			end
		end
	end

	initial begin
		#(WATCH_CLKS * 10);
		$display("watchdog expired, the tests did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int base;
		int wc;
		int src;
		int v;
		int stretch;
		int t0;
		logic [7:0] d;
		reset      = 1'b1;
		init_ram   = 1'b1;
		copy_mode  = 1'b0;
		reg_sel    = '0;
		reg_wr     = 1'b0;
		reg_rd     = 1'b0;
		reg_wdata  = '0;
		credit_ret = 1'b0;
		cfg.ht     = 8'(HT);
		cfg.hd     = 8'(HD);
		cfg.ai     = 8'(AI);
		cfg.vt     = 8'(VT);
		cfg.ds     = 16'(DS);
		cfg.drr    = 8'(DRR);
		for (int a = 0; a < RAM_SIZE; a++)
			ref_mem[a] = a[0] ? 8'h00 : 8'hFF;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check("busy after reset", busy, 1);
		check("out_valid after reset", out_valid, 0);

		// 1: erase pattern
		wait_idle();
		for (int i = 0; i < 16; i++) begin
			rand_bits(12, v);
			set_ua(v);
			read_da(d);
			check("erase pattern", d, v[0] ? 8'h00 : 8'hFF);
		end
		end_test("erase");

		// 2: write and read back
		rand_bits(6, base);
		base = base + 16'h400;
		set_ua(base);
		for (int i = 0; i < 8; i++) begin
			rand_bits(8, v);
			write_da(base + i, 8'(v));
		end
		read_back("read back", base, base + 7);
		end_test("write_read");

		// 3: fill
		rand_bits(6, base);
		base = base + 16'h480;
		rand_bits(8, v);
		set_ua(base);
		write_da(base, 8'(v));
		rand_bits(5, wc);
		wc = wc % 20 + 1;
		reg_write(6'd30, 8'(wc));
		for (int i = 1; i <= wc; i++)
			ref_mem[base + i] = 8'(v);
		read_back("fill", base - 1, base + wc + 1);
		end_test("fill");

		// 4: block copy
		rand_bits(6, src);
		src = src + 16'h500;
		rand_bits(6, base);
		base = base + 16'h580;
		set_ua(src);
		for (int i = 0; i < 20; i++) begin
			rand_bits(8, v);
			write_da(src + i, 8'(v));
		end
		rand_bits(5, wc);
		wc = wc % 20 + 1;
		reg_write(6'd32, 8'(src >> 8));
		reg_write(6'd33, 8'(src));
		set_ua(base);
		copy_mode = 1'b1;
		reg_write(6'd30, 8'(wc));
		copy_mode = 1'b0;
		for (int i = 0; i < wc; i++)
			ref_mem[base + i] = ref_mem[src + i];
		read_back("copy", base - 1, base + wc);
		end_test("copy");

		// 5: display stream over several lines and a frame wrap
		data_chk = 1'b0;  // queued words still carry the old screen bytes
		set_ua(DS);
		for (int i = 0; i < VT * (HD + AI) + HD; i++) begin
			rand_bits(8, v);
			write_da(DS + i, 8'(v));
		end
		wait_words(valids_seen + `VDC_FIFO_DEPTH + 2);
		data_chk = 1'b1;
		wait_words(valids_seen + 5 * HD * (VT + 1) / 2);
		end_test("display");

		// 6: back-pressure with a concurrent fill
		rand_bits(6, stretch);
		stretch = stretch + 40;
		held_words = 0;
		hold = 1'b1;
		rand_bits(6, base);
		base = base + 16'h600;
		set_ua(base);
		write_da(base, 8'h5A);
		reg_write(6'd30, 8'd12);
		for (int i = 1; i <= 12; i++)
			ref_mem[base + i] = 8'h5A;
		t0 = cyc;  // credits stay withheld a random stretch past the fill
		while (cyc < t0 + stretch) begin
			@(posedge clk);
			#1;
		end
		hold = 1'b0;
		if (held_words > `VDC_FIFO_DEPTH) begin
			errors++;
			$display("%0d words sent while credits were withheld", held_words);
		end
		wait_words(valids_seen + 3 * HD);
		read_back("fill under back-pressure", base - 1, base + 13);
		end_test("backpressure");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verilog
verilog/vdc_pkg.sv
verilog/vdc_cpu_port.sv
verilog/vdc_slot_sched.sv
verilog/vdc_vram.sv
verilog/vdc_fetch_out.sv
verilog/vdc_ramiface_top.sv
sim/vdc_assertions.sv
sim/vdc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vram interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module vdc_tb -f flist.f

out=$(./obj_dir/Vvdc_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
	exit 0
fi
exit 1
